//--- rtl/huntPkg.sv
`default_nettype none

package huntPkg;

	localparam int ScreenWidth = 480;
	localparam int DuckBoxSize = 32;	// Hit box edge in pixels

	// Dog rest spot and intro geometry
	localparam logic [9:0] DogStartX = 10'd11;
	localparam logic [9:0] DogGroundY = 10'd290;
	localparam logic [9:0] DogStepX = 10'd8;
	localparam logic [9:0] DogJumpStepX = 10'd9;
	localparam logic [9:0] DogJumpStepY = 10'd8;
	localparam int DogWalkFrames = 16;
	localparam int DogSniffFrames = 4;
	localparam int DogSurpriseFrames = 2;
	localparam int DogJumpHalfFrames = 10;

	// Dog sprite frame numbers
	localparam logic [5:0] DogFrameWalk = 6'd1;	// First of three walk frames
	localparam logic [5:0] DogFrameSniff = 6'd4;
	localparam logic [5:0] DogFrameSurprised = 6'd6;
	localparam logic [5:0] DogFrameJumpUp = 6'd7;
	localparam logic [5:0] DogFrameJumpDown = 6'd8;

	localparam logic [9:0] DuckLaunchY = 10'd300;
	localparam int DuckFrameColorStride = 20;
	localparam logic [5:0] DuckHitFrameOffset = 6'd8;
	localparam int DuckFlapFrames = 4;

	// Per-direction offset of the first flap frame
	localparam logic [5:0] DuckBaseNW = 6'd11;
	localparam logic [5:0] DuckBaseW = 6'd15;
	localparam logic [5:0] DuckBaseNE = 6'd0;
	localparam logic [5:0] DuckBaseE = 6'd4;

	typedef enum logic [2:0] {DogIdle, DogWalk, DogSniff, DogSurprised, DogJumpUp,
		DogJumpDown} dogStateT;
	typedef enum logic [2:0] {DuckIdle, DuckLaunch, DuckFly, DuckFall} duckStateT;
	typedef enum logic [1:0] {DirNW, DirW, DirNE, DirE} duckDirT;
	typedef enum logic [1:0] {CfgStepLarge, CfgStepSmall, CfgFlapLimit, CfgShots} cfgRegT;

	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic [5:0] frame;
	} spritePosT;

	typedef struct packed {
		logic [1:0] color;
		duckDirT dir;
		logic [9:0] startX;
	} duckLaunchT;

	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
	} shotT;

	typedef struct packed {
		cfgRegT addr;
		logic [7:0] data;
	} cfgWriteT;

	typedef struct packed {
		logic [3:0] stepLarge;
		logic [3:0] stepSmall;
		logic [3:0] flapLimit;
		logic [1:0] shotsPerDuck;
	} huntCfgT;

	localparam huntCfgT CfgDefaults = '{stepLarge: 4'd12, stepSmall: 4'd4, flapLimit: 4'd8,
		shotsPerDuck: 2'd3};

endpackage

`default_nettype wire

//--- rtl/huntConfig.sv
`timescale 1ns/10ps
`default_nettype none

module huntConfig (
	input  logic ANIM_Clk,
	input  logic Reset,
	input  logic cfgStrobe,
	input  huntPkg::cfgWriteT cfgWrite,
	output huntPkg::huntCfgT cfg
);

	import huntPkg::*;

	// Register file, one field per address
	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			cfg <= CfgDefaults;
		end
		else if (cfgStrobe)
		begin
			unique case (cfgWrite.addr)
				CfgStepLarge:
					cfg.stepLarge <= cfgWrite.data[3:0];
				CfgStepSmall:
					cfg.stepSmall <= cfgWrite.data[3:0];
				CfgFlapLimit:
					cfg.flapLimit <= cfgWrite.data[3:0];	// Upper nibble dropped
				CfgShots:
					cfg.shotsPerDuck <= cfgWrite.data[1:0];
				default:
					cfg <= cfg;
			endcase
		end
	end

	// The duck would never finish a flap cycle count of zero
	flapLimitNonZero: assert property (@(posedge ANIM_Clk) disable iff (Reset)
		cfgStrobe && cfgWrite.addr == CfgFlapLimit |-> cfgWrite.data[3:0] != 4'd0)
		else $error("huntConfig: flapLimit written as zero");

endmodule

`default_nettype wire

//--- rtl/dogSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module dogSequencer (
	input  logic ANIM_Clk,
	input  logic Reset,
	input  logic run,
	input  logic start,
	output huntPkg::spritePosT dogPos,
	output logic dogDone,
	output logic dogBusy
);

	import huntPkg::*;

	dogStateT state;
	logic [3:0] phaseCnt;	// Frames spent in the current phase
	logic [4:0] phaseLen;
	logic lastFrame;

	// Length of each intro phase
	always_comb
	begin
		unique case (state)
			DogWalk:
				phaseLen = 5'(DogWalkFrames);
			DogSniff:
				phaseLen = 5'(DogSniffFrames);
			DogSurprised:
				phaseLen = 5'(DogSurpriseFrames);
			DogJumpUp, DogJumpDown:
				phaseLen = 5'(DogJumpHalfFrames);
			default:
				phaseLen = 5'd1;
		endcase
	end

	assign lastFrame = {1'b0, phaseCnt} == phaseLen - 5'd1;

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state <= DogIdle;
			phaseCnt <= '0;
			dogPos <= '{x: DogStartX, y: DogGroundY, frame: 6'd0};
			dogDone <= 1'b0;
		end
		else
		begin
			dogDone <= 1'b0;
			phaseCnt <= lastFrame ? 4'd0 : phaseCnt + 4'd1;
			unique case (state)
				DogIdle:
				begin
					phaseCnt <= '0;
					if (start)
					begin
						state <= DogWalk;
						dogPos.x <= DogStartX + DogStepX;	// First walk frame already moved
						dogPos.frame <= DogFrameWalk;
					end
				end
				DogWalk:
					if (lastFrame)
					begin
						state <= DogSniff;
						dogPos.frame <= DogFrameSniff;
					end
					else
					begin
						dogPos.x <= dogPos.x + DogStepX;
						// Three walk frames in rotation
						dogPos.frame <= (dogPos.frame == DogFrameWalk + 6'd2) ?
							DogFrameWalk : dogPos.frame + 6'd1;
					end
				DogSniff:
					if (lastFrame)
					begin
						state <= DogSurprised;
						dogPos.frame <= DogFrameSurprised;
					end
				DogSurprised:
					if (lastFrame)
					begin
						state <= DogJumpUp;
						dogPos.x <= dogPos.x + DogJumpStepX;
						dogPos.y <= dogPos.y - DogJumpStepY;
						dogPos.frame <= DogFrameJumpUp;
					end
				DogJumpUp:
				begin
					dogPos.x <= dogPos.x + DogJumpStepX;
					if (lastFrame)	// Apex reached, turn over
					begin
						state <= DogJumpDown;
						dogPos.y <= dogPos.y + DogJumpStepY;
						dogPos.frame <= DogFrameJumpDown;
					end
					else
						dogPos.y <= dogPos.y - DogJumpStepY;
				end
				DogJumpDown:
					if (lastFrame)
					begin
						state <= DogIdle;
						dogDone <= 1'b1;
						dogPos <= '{x: DogStartX, y: DogGroundY, frame: 6'd0};
					end
					else
					begin
						dogPos.x <= dogPos.x + DogJumpStepX;
						dogPos.y <= dogPos.y + DogJumpStepY;
					end
				default:
					state <= DogIdle;
			endcase
		end
	end

	// Busy also covers the handoff cycle to the duck
	assign dogBusy = state != DogIdle || dogDone;

	doneFromJump: assert property (@(posedge ANIM_Clk) disable iff (Reset)
		dogDone |-> $past(state) == DogJumpDown)
		else $error("dogSequencer: dogDone outside the jump-down phase");

	// Top only lets run through while nothing is on screen
	startQualified: assert property (@(posedge ANIM_Clk) disable iff (Reset)
		start |-> run && state == DogIdle)
		else $error("dogSequencer: start while busy");

endmodule

`default_nettype wire

//--- rtl/duckFlight.sv
`timescale 1ns/10ps
`default_nettype none

module duckFlight (
	input  logic ANIM_Clk,
	input  logic Reset,
	input  logic dogDone,
	input  huntPkg::duckLaunchT launch,
	input  huntPkg::huntCfgT cfg,
	input  logic duckKill,
	output huntPkg::spritePosT duckPos,
	output logic duckVisible,
	output logic duckFlying,
	output logic duckLaunched,
	output logic duckDown,
	output logic duckEscaped,
	output logic [1:0] duckColor
);

	import huntPkg::*;

	duckStateT state;
	duckDirT dirQ;
	logic [1:0] colorQ;
	logic [1:0] launchColor;
	logic [1:0] flapPhase;
	logic [3:0] flapCount;	// Completed flap cycles
	logic [5:0] base;
	logic signed [11:0] nextX, nextY;
	logic signed [11:0] stepLarge, stepSmall;
	logic [10:0] fallY;
	logic offScreen, flapDone;

	function automatic logic [5:0] frameBase(input logic [1:0] color, input duckDirT dir);
		logic [5:0] dirOffset;
		unique case (dir)
			DirNW: dirOffset = DuckBaseNW;
			DirW: dirOffset = DuckBaseW;
			DirNE: dirOffset = DuckBaseNE;
			default: dirOffset = DuckBaseE;
		endcase
		return 6'(color * DuckFrameColorStride) + dirOffset;
	endfunction

	// Only three palettes, colour 3 falls back to black
	assign launchColor = (launch.color == 2'd3) ? 2'd0 : launch.color;
	assign base = frameBase(colorQ, dirQ);

	assign stepLarge = $signed({8'b0, cfg.stepLarge});
	assign stepSmall = $signed({8'b0, cfg.stepSmall});

	// Position one step ahead, signed so the edge test sees underflow
	always_comb
	begin
		nextX = $signed({2'b00, duckPos.x});
		nextY = $signed({2'b00, duckPos.y});
		unique case (dirQ)
			DirNW:
			begin
				nextX = nextX - stepSmall;
				nextY = nextY - stepLarge;
			end
			DirW:
			begin
				nextX = nextX - stepLarge;
				nextY = nextY - stepSmall;
			end
			DirNE:
			begin
				nextX = nextX + stepSmall;
				nextY = nextY - stepLarge;
			end
			default:
			begin
				nextX = nextX + stepLarge;
				nextY = nextY - stepSmall;
			end
		endcase
	end

	assign offScreen = nextX < 0 || nextX > ScreenWidth - DuckBoxSize || nextY < 0;
	assign flapDone = flapPhase == 2'(DuckFlapFrames - 1) && flapCount == cfg.flapLimit - 4'd1;
	assign fallY = {1'b0, duckPos.y} + {7'b0, cfg.stepLarge};

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state <= DuckIdle;
			dirQ <= DirNE;
			colorQ <= '0;
			flapPhase <= '0;
			flapCount <= '0;
			duckPos <= '0;
			duckLaunched <= 1'b0;
			duckDown <= 1'b0;
			duckEscaped <= 1'b0;
		end
		else
		begin
			duckLaunched <= 1'b0;
			duckDown <= 1'b0;
			duckEscaped <= 1'b0;
			unique case (state)
				DuckIdle:
					if (dogDone)
					begin
						state <= DuckLaunch;
						colorQ <= launchColor;
						dirQ <= launch.dir;
						duckPos <= '{x: launch.startX, y: DuckLaunchY,
							frame: frameBase(launchColor, launch.dir)};
						flapPhase <= '0;
						flapCount <= '0;
					end
				DuckLaunch:
				begin
					state <= DuckFly;
					duckLaunched <= 1'b1;	// Scorer reloads its shots
				end
				DuckFly:
					if (duckKill)
					begin
						state <= DuckFall;
						duckPos.frame <= {base[5:2], 2'b00} + DuckHitFrameOffset;
					end
					else if (offScreen || flapDone)
					begin
						state <= DuckIdle;
						duckEscaped <= 1'b1;
					end
					else
					begin
						duckPos.x <= nextX[9:0];
						duckPos.y <= nextY[9:0];
						flapPhase <= flapPhase + 2'd1;
						duckPos.frame <= base + {4'b0, flapPhase + 2'd1};
						if (flapPhase == 2'(DuckFlapFrames - 1))
							flapCount <= flapCount + 4'd1;
					end
				DuckFall:
				begin
					duckPos.y <= fallY[9:0];
					if (fallY >= {1'b0, DuckLaunchY})	// Back in the grass
					begin
						state <= DuckIdle;
						duckDown <= 1'b1;
					end
				end
				default:
					state <= DuckIdle;
			endcase
		end
	end

	assign duckVisible = state != DuckIdle;
	assign duckFlying = state == DuckFly;
	assign duckColor = colorQ;

	killWhileFlying: assert property (@(posedge ANIM_Clk) disable iff (Reset)
		duckKill |-> state == DuckFly)
		else $error("duckFlight: duckKill outside DuckFly");

endmodule

`default_nettype wire

//--- rtl/shotScorer.sv
`timescale 1ns/10ps
`default_nettype none

module shotScorer (
	input  logic ANIM_Clk,
	input  logic Reset,
	input  logic shotStrobe,
	input  huntPkg::shotT shot,
	input  huntPkg::spritePosT duckPos,
	input  logic duckFlying,
	input  logic duckLaunched,
	input  huntPkg::huntCfgT cfg,
	output logic duckKill,
	output logic [1:0] shotsLeft,
	output logic [7:0] hitCount
);

	import huntPkg::*;

	logic killPending;
	logic shotValid;
	logic inBox;
	logic [10:0] boxRight, boxBottom;	// Inclusive far corner of the hit box

	assign boxRight = {1'b0, duckPos.x} + 11'(DuckBoxSize - 1);
	assign boxBottom = {1'b0, duckPos.y} + 11'(DuckBoxSize - 1);

	assign inBox = shot.x >= duckPos.x && {1'b0, shot.x} <= boxRight &&
		shot.y >= duckPos.y && {1'b0, shot.y} <= boxBottom;

	// Shots count only while the duck flies and ammo remains
	assign shotValid = shotStrobe && duckFlying && shotsLeft != 2'd0;

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			killPending <= 1'b0;
			shotsLeft <= '0;
			hitCount <= '0;
		end
		else
		begin
			killPending <= shotValid && inBox;
			if (duckLaunched)
				shotsLeft <= cfg.shotsPerDuck;
			else if (shotValid)
				shotsLeft <= shotsLeft - 2'd1;
			if (shotValid && inBox)
				hitCount <= hitCount + 8'd1;
		end
	end

	// Dropped if the duck got away on the same edge
	assign duckKill = killPending && duckFlying;

	singleKill: assert property (@(posedge ANIM_Clk) disable iff (Reset)
		duckKill |=> !duckKill)
		else $error("shotScorer: duckKill held for two cycles");

endmodule

`default_nettype wire

//--- rtl/huntTop.sv
`timescale 1ns/10ps
`default_nettype none

module huntTop (
	input  logic ANIM_Clk,
	input  logic Reset,
	input  logic run,
	input  huntPkg::duckLaunchT launch,
	input  logic shotStrobe,
	input  huntPkg::shotT shot,
	input  logic cfgStrobe,
	input  huntPkg::cfgWriteT cfgWrite,
	output huntPkg::spritePosT dogPos,
	output huntPkg::spritePosT duckPos,
	output logic duckVisible,
	output logic [1:0] duckColor,
	output logic duckDown,
	output logic duckEscaped,
	output logic [1:0] shotsLeft,
	output logic [7:0] hitCount,
	output logic busy
);

	import huntPkg::*;

	huntCfgT cfg;
	logic start;
	logic dogDone, dogBusy;
	logic duckFlying, duckLaunched, duckKill;

	assign busy = dogBusy || duckVisible;
	assign start = run && !busy;	// A run while busy is dropped

	huntConfig config0 (
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.cfgStrobe(cfgStrobe),
		.cfgWrite(cfgWrite),
		.cfg(cfg)
	);

	dogSequencer dog0 (
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.run(run),
		.start(start),
		.dogPos(dogPos),
		.dogDone(dogDone),
		.dogBusy(dogBusy)
	);

	duckFlight duck0 (
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.dogDone(dogDone),
		.launch(launch),
		.cfg(cfg),
		.duckKill(duckKill),
		.duckPos(duckPos),
		.duckVisible(duckVisible),
		.duckFlying(duckFlying),
		.duckLaunched(duckLaunched),
		.duckDown(duckDown),
		.duckEscaped(duckEscaped),
		.duckColor(duckColor)
	);

	shotScorer scorer0 (
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.shotStrobe(shotStrobe),
		.shot(shot),
		.duckPos(duckPos),
		.duckFlying(duckFlying),
		.duckLaunched(duckLaunched),
		.cfg(cfg),
		.duckKill(duckKill),
		.shotsLeft(shotsLeft),
		.hitCount(hitCount)
	);

endmodule

`default_nettype wire

//--- verification/huntTb.sv
`timescale 1ns/10ps
`default_nettype none

module huntTb;

	import huntPkg::*;

	logic ANIM_Clk = 1'b0;
	logic Reset;
	logic run;
	duckLaunchT launch;
	logic shotStrobe;
	shotT shot;
	logic cfgStrobe;
	cfgWriteT cfgWrite;
	spritePosT dogPos, duckPos;
	logic duckVisible, duckDown, duckEscaped, busy;
	logic [1:0] duckColor, shotsLeft;
	logic [7:0] hitCount;

	int errorCount = 0;
	int checkCount = 0;
	int expHits = 0;
	int unsigned lcgState = 84036;
	// Model copy of the config registers
	int cfgLarge = 12;
	int cfgSmall = 4;
	int cfgFlap = 8;
	int cfgShots = 3;

	huntTop dut0 (
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.run(run),
		.launch(launch),
		.shotStrobe(shotStrobe),
		.shot(shot),
		.cfgStrobe(cfgStrobe),
		.cfgWrite(cfgWrite),
		.dogPos(dogPos),
		.duckPos(duckPos),
		.duckVisible(duckVisible),
		.duckColor(duckColor),
		.duckDown(duckDown),
		.duckEscaped(duckEscaped),
		.shotsLeft(shotsLeft),
		.hitCount(hitCount),
		.busy(busy)
	);

	always #20 ANIM_Clk = ~ANIM_Clk;	// 40 ns frame

	function automatic int nextRand(input int bound);
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return int'((lcgState >> 16) % bound);
	endfunction

	// Dog position in intro frame n counted from 1
	function automatic spritePosT dogModel(input int n);
		int x, y, frame, walkEndX, apexX, apexY;
		walkEndX = DogStartX + DogStepX * DogWalkFrames;
		apexX = walkEndX + DogJumpStepX * DogJumpHalfFrames;
		apexY = DogGroundY - DogJumpStepY * DogJumpHalfFrames;
		y = DogGroundY;
		if (n <= 16)
		begin
			x = DogStartX + DogStepX * n;
			frame = 1 + (n - 1) % 3;
		end
		else if (n <= 20)
		begin
			x = walkEndX;
			frame = 4;
		end
		else if (n <= 22)
		begin
			x = walkEndX;
			frame = 6;
		end
		else if (n <= 32)
		begin
			x = walkEndX + DogJumpStepX * (n - 22);
			y = DogGroundY - DogJumpStepY * (n - 22);
			frame = 7;
		end
		else
		begin
			x = apexX + DogJumpStepX * (n - 32);
			y = apexY + DogJumpStepY * (n - 32);
			frame = 8;
		end
		return '{x: 10'(x), y: 10'(y), frame: 6'(frame)};
	endfunction

	function automatic int flapBase(input int color, input int dir);
		int offset;
		case (dir)
			DirNW: offset = 11;
			DirW: offset = 15;
			DirNE: offset = 0;
			default: offset = 4;
		endcase
		return color * DuckFrameColorStride + offset;
	endfunction

	task automatic compare(input string name, input int got, input int exp);
		checkCount++;
		if (got != exp)
		begin
			errorCount++;
			$display("Fail %0t %s expected %0d got %0d", $time, name, exp, got);
		end
	endtask

	task automatic writeConfig(input cfgRegT addr, input int data);
		@(negedge ANIM_Clk);
		cfgWrite = '{addr: addr, data: 8'(data)};
		cfgStrobe = 1'b1;
		@(negedge ANIM_Clk);
		cfgStrobe = 1'b0;
	endtask

	task automatic checkReset();
		compare("busy", busy, 0);
		compare("duckVisible", duckVisible, 0);
		compare("hitCount", hitCount, 0);
		compare("shotsLeft", shotsLeft, 0);
		compare("duckDown", duckDown, 0);
		compare("duckEscaped", duckEscaped, 0);
		compare("dogPos.x", dogPos.x, DogStartX);
		compare("dogPos.y", dogPos.y, DogGroundY);
		compare("dogPos.frame", dogPos.frame, 0);
	endtask

	// Flight from the first DuckFly frame until the duck escapes or lands
	task automatic followDuck(input int color, input int dir, input int startX,
		input int firstShot, input int nShots, input int nMiss);
		int x, y, nx, ny, s, f, n, base, shotsModel, outcome;
		bit hitNow, killArmed;
		x = startX;
		y = DuckLaunchY;
		s = 0;
		base = flapBase(color, dir);
		shotsModel = cfgShots;
		killArmed = 1'b0;
		outcome = 0;
		for (f = 0; f < 200 && outcome == 0; f++)
		begin
			@(negedge ANIM_Clk);
			compare("duckPos.x", duckPos.x, x);
			compare("duckPos.y", duckPos.y, y);
			compare("duckPos.frame", duckPos.frame, base + s % DuckFlapFrames);
			compare("duckVisible", duckVisible, 1);
			compare("duckEscaped", duckEscaped, 0);
			compare("hitCount", hitCount, expHits);
			compare("busy", busy, 1);
			compare("dogPos.x", dogPos.x, DogStartX);
			compare("dogPos.frame", dogPos.frame, 0);
			if (f > 0)	// Reload lands after the first flying frame
				compare("shotsLeft", shotsLeft, shotsModel);
			run = f == 1;	// Dropped while the duck is on screen
			shotStrobe = 1'b0;
			hitNow = 1'b0;
			if (f >= firstShot && f < firstShot + nShots)
			begin
				shotStrobe = 1'b1;
				if (f - firstShot < nMiss)
					shot = '{x: 10'((x + 200) % ScreenWidth), y: 10'(y + 16)};
				else
					shot = '{x: 10'(x + DuckBoxSize / 2), y: 10'(y + DuckBoxSize / 2)};
				if (shotsModel > 0)
				begin
					shotsModel--;
					hitNow = shot.x >= x && shot.x <= x + DuckBoxSize - 1 &&
						shot.y >= y && shot.y <= y + DuckBoxSize - 1;
					if (hitNow)
						expHits++;
				end
			end
			nx = x;
			ny = y;
			case (dir)
				DirNW:
				begin
					nx = x - cfgSmall;
					ny = y - cfgLarge;
				end
				DirW:
				begin
					nx = x - cfgLarge;
					ny = y - cfgSmall;
				end
				DirNE:
				begin
					nx = x + cfgSmall;
					ny = y - cfgLarge;
				end
				default:
				begin
					nx = x + cfgLarge;
					ny = y - cfgSmall;
				end
			endcase
			// Last frame of the final flap cycle also ends the flight
			if (killArmed)
				outcome = 2;
			else if (nx < 0 || nx > ScreenWidth - DuckBoxSize || ny < 0 ||
				s == DuckFlapFrames * cfgFlap - 1)
				outcome = 1;
			else
			begin
				x = nx;
				y = ny;
				s++;
			end
			killArmed = hitNow;
		end
		@(negedge ANIM_Clk);
		shotStrobe = 1'b0;
		run = 1'b0;
		if (outcome == 0)
		begin
			errorCount++;
			$display("Timeout at %0t: the duck never left the sky", $time);
		end
		else if (outcome == 1)
		begin
			compare("duckEscaped", duckEscaped, 1);
			compare("duckVisible", duckVisible, 0);
			compare("hitCount", hitCount, expHits);
		end
		else
		begin
			compare("duckPos.frame", duckPos.frame, (base & ~3) + DuckHitFrameOffset);
			compare("duckPos.x", duckPos.x, x);
			compare("duckPos.y", duckPos.y, y);
			for (n = 0; n < 40 && outcome == 2; n++)
			begin
				@(negedge ANIM_Clk);
				y += cfgLarge;
				compare("duckPos.y", duckPos.y, y);
				if (y >= DuckLaunchY)
				begin
					compare("duckDown", duckDown, 1);
					compare("duckVisible", duckVisible, 0);
					outcome = 3;
				end
				else
					compare("duckDown", duckDown, 0);
			end
			if (outcome != 3)
			begin
				errorCount++;
				$display("Timeout at %0t: the falling duck never reached the grass", $time);
			end
		end
	endtask

	// Intro, launch and flight of one duck
	task automatic huntDuck(input int color, input int dir, input int startX,
		input bit checkDog, input int firstShot, input int nShots, input int nMiss);
		spritePosT expDog;
		int n;
		bit seen;
		launch = '{color: 2'(color), dir: duckDirT'(dir), startX: 10'(startX)};
		run = 1'b1;
		for (n = 1; n <= 42; n++)
		begin
			@(negedge ANIM_Clk);
			run = 1'b0;
			if (checkDog)
			begin
				expDog = dogModel(n);
				compare("dogPos.x", dogPos.x, expDog.x);
				compare("dogPos.y", dogPos.y, expDog.y);
				compare("dogPos.frame", dogPos.frame, expDog.frame);
				compare("busy", busy, 1);
			end
		end
		seen = 1'b0;
		for (n = 0; n < 10 && !seen; n++)
		begin
			@(negedge ANIM_Clk);
			seen = duckVisible;
			run = checkDog && n == 0;	// Dropped in the handoff cycle to the duck
		end
		if (!seen)
		begin
			errorCount++;
			$display("Timeout at %0t: no duck appeared after the dog intro", $time);
		end
		else
		begin
			compare("duckPos.x", duckPos.x, startX);
			compare("duckPos.y", duckPos.y, DuckLaunchY);
			compare("duckPos.frame", duckPos.frame, flapBase(color, dir));
			compare("duckColor", duckColor, color);
			if (checkDog)
			begin
				compare("dogPos.x", dogPos.x, DogStartX);
				compare("dogPos.y", dogPos.y, DogGroundY);
				compare("dogPos.frame", dogPos.frame, 0);
			end
			followDuck(color, dir, startX, firstShot, nShots, nMiss);
		end
	endtask

	initial
	begin
		int color, dir, startX, i;
		Reset = 1'b1;
		run = 1'b0;
		launch = '0;
		shotStrobe = 1'b0;
		shot = '0;
		cfgStrobe = 1'b0;
		cfgWrite = '0;
		repeat (10) @(negedge ANIM_Clk);
		Reset = 1'b0;

		checkReset();
		huntDuck(1, DirNE, 200, 1'b1, 0, 0, 0);

		// Escapes to each side from random spots
		color = nextRand(3);
		startX = 100 + nextRand(349);
		huntDuck(color, DirW, startX, 1'b0, 0, 0, 0);
		color = nextRand(3);
		startX = nextRand(449);
		huntDuck(color, DirE, startX, 1'b0, 0, 0, 0);

		huntDuck(2, DirNE, 60, 1'b0, 4, 1, 0);	// One shot dead centre
		huntDuck(0, DirE, 20, 1'b0, 2, 4, 3);	// Three misses and then no ammo

		writeConfig(CfgStepLarge, 6);
		cfgLarge = 6;
		writeConfig(CfgFlapLimit, 2);
		cfgFlap = 2;
		for (i = 0; i < 2; i++)
		begin
			color = nextRand(3);
			dir = nextRand(4);
			startX = nextRand(449);
			huntDuck(color, dir, startX, 1'b0, 0, 0, 0);
		end

		$display("Checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
rtl/huntPkg.sv
rtl/huntConfig.sv
rtl/dogSequencer.sv
rtl/duckFlight.sv
rtl/shotScorer.sv
rtl/huntTop.sv
verification/huntTb.sv
